//--- build.f
+incdir+design
design/simt_pkg.sv
design/exec_if.sv
design/result_if.sv
design/lane_regfile.sv
design/operand_collect.sv
design/simt_alu.sv
design/writeback_route.sv
design/simt_exec_top.sv
dv/simt_exec_tb.sv

//--- design/exec_if.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

// decoded instruction plus operands, collector -> alu
interface exec_if;
    import simt_pkg::*;

    logic                               valid;
    logic [`WARP_W-1:0]                 warp;
    logic [`NUM_LANES-1:0]              mask;
    logic [`REG_W-1:0]                  dst;
    logic [15:0]                        imm;
    logic                               imm_valid;
    logic                               reg_write;
    alu_op_e                            alu_op;
    logic                               beq;
    logic                               blt;
    logic [`SCB_W-1:0]                  scb;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] src1;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] src2;

    modport collector (output valid, warp, mask, dst, imm, imm_valid, reg_write,
                       output alu_op, beq, blt, scb, src1, src2);
    modport alu (input valid, warp, mask, dst, imm, imm_valid, reg_write,
                 input alu_op, beq, blt, scb, src1, src2);

endinterface

//--- design/lane_regfile.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

module lane_regfile (
    input  logic                               clk,
    input  logic                               rst,

    // read side, from the collector
    input  logic [`WARP_W-1:0]                 rd_warp,
    input  logic [`REG_W-1:0]                  rd_rs,
    input  logic [`REG_W-1:0]                  rd_rt,
    output logic [`NUM_LANES-1:0][`DATA_W-1:0] rd_src1,
    output logic [`NUM_LANES-1:0][`DATA_W-1:0] rd_src2,

    // write side, from writeback
    input  logic                               wr_en,
    input  logic [`WARP_W-1:0]                 wr_warp,
    input  logic [`REG_W-1:0]                  wr_dst,
    input  logic [`NUM_LANES-1:0]              wr_mask,
    input  logic [`NUM_LANES-1:0][`DATA_W-1:0] wr_data
);

    // warp x register x lane
    logic [`DATA_W-1:0] mem [1 << `WARP_W][1 << `REG_W][`NUM_LANES];

    //////////////////////////////////////////////////
    // masked write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < (1 << `WARP_W); w++) begin
                for (int r = 0; r < (1 << `REG_W); r++) begin
                    for (int i = 0; i < `NUM_LANES; i++) begin
                        mem[w][r][i] <= '0;
                    end
                end
            end
        end else if (wr_en && (wr_dst != '0)) begin   // r0 stays zero
            for (int i = 0; i < `NUM_LANES; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_warp][wr_dst][i] <= wr_data[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // combinational read ports
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (rd_rs == '0) begin
                rd_src1[i] = '0;
            end else begin
                rd_src1[i] = mem[rd_warp][rd_rs][i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (rd_rt == '0) begin
                rd_src2[i] = '0;
            end else begin
                rd_src2[i] = mem[rd_warp][rd_rt][i];
            end
        end
    end

endmodule

//--- design/operand_collect.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

module operand_collect (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issue_valid,
    input  logic [`WARP_W-1:0]                 issue_warp,
    input  logic [`NUM_LANES-1:0]              issue_mask,
    input  simt_pkg::instr_u                   issue_instr,
    input  logic [`SCB_W-1:0]                  issue_scb,
    output logic [`WARP_W-1:0]                 rd_warp,
    output logic [`REG_W-1:0]                  rd_rs,
    output logic [`REG_W-1:0]                  rd_rt,
    input  logic [`NUM_LANES-1:0][`DATA_W-1:0] rd_src1,
    input  logic [`NUM_LANES-1:0][`DATA_W-1:0] rd_src2,
    exec_if.collector                          exec
);
    import simt_pkg::*;

    opcode_e op;
    alu_op_e alu_op;
    logic    imm_valid;
    logic    reg_write;
    logic    beq;
    logic    blt;

    assign op      = issue_instr.r_form.opcode;
    assign rd_warp = issue_warp;
    assign rd_rs   = issue_instr.r_form.rs;
    assign rd_rt   = issue_instr.r_form.rt;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        imm_valid = 1'b0;
        reg_write = 1'b0;
        beq       = 1'b0;
        blt       = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_SHR, OP_SHL: begin
                alu_op    = alu_op_e'({1'b0, op[2:0]});   // codes match 1:1
                reg_write = 1'b1;
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: begin
                imm_valid = 1'b1;
                reg_write = 1'b1;
                case (op)
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LID: begin
                alu_op    = ALU_LID;
                reg_write = 1'b1;
            end
            OP_BEQ:  beq = 1'b1;
            OP_BLT:  blt = 1'b1;
            default: ;   // nop, valid travels but nothing retires
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= issue_valid;
        end
    end

    // payload toward the alu
    always_ff @(posedge clk) begin
        exec.warp      <= issue_warp;
        exec.mask      <= issue_mask;
        exec.dst       <= issue_instr.r_form.rd;
        exec.imm       <= issue_instr.i_form.imm;
        exec.imm_valid <= imm_valid;
        exec.reg_write <= reg_write;
        exec.alu_op    <= alu_op;
        exec.beq       <= beq;
        exec.blt       <= blt;
        exec.scb       <= issue_scb;
        exec.src1      <= rd_src1;
        exec.src2      <= rd_src2;
    end

endmodule

//--- design/result_if.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

// alu results toward writeback
interface result_if;

    logic                               valid;
    logic [`WARP_W-1:0]                 warp;
    logic [`NUM_LANES-1:0]              mask;
    logic [`REG_W-1:0]                  dst;
    logic                               reg_write;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] data;
    logic                               branch;
    logic [`NUM_LANES-1:0]              taken;
    logic [`DATA_W-1:0]                 target;   // same for every lane
    logic [`SCB_W-1:0]                  scb;

    modport driver (output valid, warp, mask, dst, reg_write, data,
                    output branch, taken, target, scb);
    modport receiver (input valid, warp, mask, dst, reg_write, data,
                      input branch, taken, target, scb);

endinterface

//--- design/simt_alu.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

module simt_alu (
    input  logic     clk,
    input  logic     rst,
    exec_if.alu      exec,
    result_if.driver res
);
    import simt_pkg::*;

    logic                               valid_q;
    logic [`WARP_W-1:0]                 warp_q;
    logic [`NUM_LANES-1:0]              mask_q;
    logic [`REG_W-1:0]                  dst_q;
    logic [15:0]                        imm_q;
    logic                               imm_valid_q;
    logic                               reg_write_q;
    alu_op_e                            alu_op_q;
    logic                               beq_q;
    logic                               blt_q;
    logic [`SCB_W-1:0]                  scb_q;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] src1_q;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] src2_q;
    logic [`DATA_W-1:0]                 imm_ext;

    //////////////////////////////////////////////////
    // input register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        warp_q      <= exec.warp;
        mask_q      <= exec.mask;
        dst_q       <= exec.dst;
        imm_q       <= exec.imm;
        imm_valid_q <= exec.imm_valid;
        reg_write_q <= exec.reg_write;
        alu_op_q    <= exec.alu_op;
        beq_q       <= exec.beq;
        blt_q       <= exec.blt;
        scb_q       <= exec.scb;
        src1_q      <= exec.src1;
        src2_q      <= exec.src2;
    end

    assign imm_ext = {{(`DATA_W - 16){imm_q[15]}}, imm_q};

    //////////////////////////////////////////////////
    // lane datapath
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;       // src2 or sign-extended imm
        logic signed [15:0] a_lo;
        logic signed [15:0] b_lo;
        logic signed [31:0] prod;
        logic [`DATA_W-1:0] y;

        assign a    = src1_q[i];
        assign b    = imm_valid_q ? imm_ext : src2_q[i];
        assign a_lo = src1_q[i][15:0];
        assign b_lo = src2_q[i][15:0];
        assign prod = a_lo * b_lo;   // 16x16 signed

        always_comb begin
            case (alu_op_q)
                ALU_ADD: y = a + b;
                ALU_SUB: y = a - src2_q[i];
                ALU_MUL: y = `DATA_W'(prod);
                ALU_AND: y = a & b;
                ALU_OR:  y = a | b;
                ALU_XOR: y = a ^ b;
                ALU_SHR: y = a >> src2_q[i][4:0];
                ALU_SHL: y = a << src2_q[i][4:0];
                ALU_LID: y = `DATA_W'(i);
                default: y = '0;
            endcase
        end

        assign res.data[i] = y;

        // blt compares the signed low halves only
        assign res.taken[i] = mask_q[i] & ((beq_q & (a == src2_q[i])) |
                                           (blt_q & (a_lo < b_lo)));
    end

    assign res.valid     = valid_q;
    assign res.warp      = warp_q;
    assign res.mask      = mask_q;
    assign res.dst       = dst_q;
    assign res.reg_write = reg_write_q;
    assign res.branch    = beq_q | blt_q;
    assign res.target    = `DATA_W'({imm_q, 2'b00});   // word address to byte
    assign res.scb       = scb_q;

endmodule

//--- design/simt_cfg.svh
`ifndef SIMT_CFG_SVH
`define SIMT_CFG_SVH

//////////////////////////////////////////////////
// slice dimensions
//////////////////////////////////////////////////

// lanes per warp
`define NUM_LANES 8

// warp id width, eight warps
`define WARP_W 3

// register index width, r0 hardwired to zero
`define REG_W 5

`define SCB_W 2   // scoreboard tag
`define DATA_W 32 // lane word

`endif

//--- design/simt_exec_top.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

module simt_exec_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               issue_valid,
    input  logic [`WARP_W-1:0]                 issue_warp,
    input  logic [`NUM_LANES-1:0]              issue_mask,
    input  logic [31:0]                        issue_instr,
    input  logic [`SCB_W-1:0]                  issue_scb,
    output logic                               wb_valid,
    output logic [`WARP_W-1:0]                 wb_warp,
    output logic [`REG_W-1:0]                  wb_dst,
    output logic [`NUM_LANES-1:0]              wb_mask,
    output logic [`NUM_LANES-1:0][`DATA_W-1:0] wb_data,
    output logic                               br_valid,
    output logic [`WARP_W-1:0]                 br_warp,
    output logic [`NUM_LANES-1:0]              br_taken,
    output logic [`DATA_W-1:0]                 br_target,
    output logic                               scb_clear_valid,
    output logic [`WARP_W-1:0]                 scb_clear_warp,
    output logic [`SCB_W-1:0]                  scb_clear_id
);

    // register file read side
    logic [`WARP_W-1:0]                 rd_warp;
    logic [`REG_W-1:0]                  rd_rs;
    logic [`REG_W-1:0]                  rd_rt;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] rd_src1;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] rd_src2;

    // register file write side
    logic                               wr_en;
    logic [`WARP_W-1:0]                 wr_warp;
    logic [`REG_W-1:0]                  wr_dst;
    logic [`NUM_LANES-1:0]              wr_mask;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] wr_data;

    exec_if   u_exec_if ();
    result_if u_result_if ();

    operand_collect u_operand_collect (
        .clk, .rst, .issue_valid, .issue_warp, .issue_mask, .issue_instr, .issue_scb,
        .rd_warp, .rd_rs, .rd_rt, .rd_src1, .rd_src2, .exec (u_exec_if.collector)
    );

    lane_regfile u_lane_regfile (
        .clk, .rst, .rd_warp, .rd_rs, .rd_rt, .rd_src1, .rd_src2,
        .wr_en, .wr_warp, .wr_dst, .wr_mask, .wr_data
    );

    simt_alu u_simt_alu (.clk, .rst, .exec (u_exec_if.alu), .res (u_result_if.driver));

    writeback_route u_writeback_route (
        .clk, .rst, .res (u_result_if.receiver),
        .wr_en, .wr_warp, .wr_dst, .wr_mask, .wr_data,
        .wb_valid, .wb_warp, .wb_dst, .wb_mask, .wb_data,
        .br_valid, .br_warp, .br_taken, .br_target,
        .scb_clear_valid, .scb_clear_warp, .scb_clear_id
    );

endmodule

//--- design/simt_pkg.sv
`include "simt_cfg.svh"

package simt_pkg;

    // instruction opcodes, bits 31:28 of the word
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,  OP_SUB  = 4'd1,  OP_MUL  = 4'd2,  OP_AND  = 4'd3,
        OP_OR   = 4'd4,  OP_XOR  = 4'd5,  OP_SHR  = 4'd6,  OP_SHL  = 4'd7,
        OP_ADDI = 4'd8,  OP_ANDI = 4'd9,  OP_ORI  = 4'd10, OP_XORI = 4'd11,
        OP_LID  = 4'd12, OP_BEQ  = 4'd13, OP_BLT  = 4'd14, OP_NOP  = 4'd15
    } opcode_e;

    // alu codes 0..7 line up with the register-form opcodes
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_MUL = 4'd2, ALU_AND = 4'd3,
        ALU_OR  = 4'd4, ALU_XOR = 4'd5, ALU_SHR = 4'd6, ALU_SHL = 4'd7,
        ALU_LID = 4'd8
    } alu_op_e;

    typedef struct packed {
        opcode_e           opcode;
        logic [`REG_W-1:0] rd;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [12:0]       unused;
    } r_form_t;

    typedef struct packed {
        opcode_e            opcode;
        logic [`REG_W-1:0]  rd;
        logic [`REG_W-1:0]  rs;
        logic [1:0]         pad;
        logic signed [15:0] imm;   // also the branch target
    } i_form_t;

    // branches take rs/rt from r_form and the target from i_form
    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_u;

endpackage

//--- design/writeback_route.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

module writeback_route (
    input  logic                               clk,
    input  logic                               rst,
    result_if.receiver                         res,
    output logic                               wr_en,
    output logic [`WARP_W-1:0]                 wr_warp,
    output logic [`REG_W-1:0]                  wr_dst,
    output logic [`NUM_LANES-1:0]              wr_mask,
    output logic [`NUM_LANES-1:0][`DATA_W-1:0] wr_data,
    output logic                               wb_valid,
    output logic [`WARP_W-1:0]                 wb_warp,
    output logic [`REG_W-1:0]                  wb_dst,
    output logic [`NUM_LANES-1:0]              wb_mask,
    output logic [`NUM_LANES-1:0][`DATA_W-1:0] wb_data,
    output logic                               br_valid,
    output logic [`WARP_W-1:0]                 br_warp,
    output logic [`NUM_LANES-1:0]              br_taken,
    output logic [`DATA_W-1:0]                 br_target,
    output logic                               scb_clear_valid,
    output logic [`WARP_W-1:0]                 scb_clear_warp,
    output logic [`SCB_W-1:0]                  scb_clear_id
);

    logic                               wb_q;
    logic                               br_q;
    logic [`WARP_W-1:0]                 warp_q;
    logic [`REG_W-1:0]                  dst_q;
    logic [`NUM_LANES-1:0]              mask_q;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] data_q;
    logic [`NUM_LANES-1:0]              taken_q;
    logic [`DATA_W-1:0]                 target_q;
    logic [`SCB_W-1:0]                  scb_q;

    // split by kind, nop sets neither
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_q <= 1'b0;
            br_q <= 1'b0;
        end else begin
            wb_q <= res.valid & res.reg_write;
            br_q <= res.valid & res.branch;
        end
    end

    always_ff @(posedge clk) begin
        warp_q   <= res.warp;
        dst_q    <= res.dst;
        mask_q   <= res.mask;
        data_q   <= res.data;
        taken_q  <= res.taken;
        target_q <= res.target;
        scb_q    <= res.scb;
    end

    //////////////////////////////////////////////////
    // register file write and writeback ports
    //////////////////////////////////////////////////

    assign wr_en    = wb_q;
    assign wr_warp  = warp_q;
    assign wr_dst   = dst_q;
    assign wr_mask  = mask_q;
    assign wr_data  = data_q;

    assign wb_valid = wb_q;
    assign wb_warp  = warp_q;
    assign wb_dst   = dst_q;
    assign wb_mask  = mask_q;
    assign wb_data  = data_q;

    // branches retire here, so their scoreboard entry clears with them
    assign br_valid        = br_q;
    assign br_warp         = warp_q;
    assign br_taken        = taken_q;
    assign br_target       = target_q;
    assign scb_clear_valid = br_q;
    assign scb_clear_warp  = warp_q;
    assign scb_clear_id    = scb_q;

endmodule

//--- dv/simt_exec_tb.sv
`timescale 1ns/1ps
`include "simt_cfg.svh"

module simt_exec_tb;
    import simt_pkg::*;

    // one retirement slot three edges after issue
    typedef struct {
        bit                               wb;
        bit                               br;
        bit [`WARP_W-1:0]                 warp;
        bit [`REG_W-1:0]                  dst;
        bit [`NUM_LANES-1:0]              mask;
        bit [`NUM_LANES-1:0][`DATA_W-1:0] data;
        bit [`NUM_LANES-1:0]              taken;
        bit [`DATA_W-1:0]                 target;
        bit [`SCB_W-1:0]                  scb;
    } expect_t;

    logic                               clk;
    logic                               rst;
    logic                               issue_valid;
    logic [`WARP_W-1:0]                 issue_warp;
    logic [`NUM_LANES-1:0]              issue_mask;
    logic [31:0]                        issue_instr;
    logic [`SCB_W-1:0]                  issue_scb;
    logic                               wb_valid;
    logic [`WARP_W-1:0]                 wb_warp;
    logic [`REG_W-1:0]                  wb_dst;
    logic [`NUM_LANES-1:0]              wb_mask;
    logic [`NUM_LANES-1:0][`DATA_W-1:0] wb_data;
    logic                               br_valid;
    logic [`WARP_W-1:0]                 br_warp;
    logic [`NUM_LANES-1:0]              br_taken;
    logic [`DATA_W-1:0]                 br_target;
    logic                               scb_clear_valid;
    logic [`WARP_W-1:0]                 scb_clear_warp;
    logic [`SCB_W-1:0]                  scb_clear_id;

    bit [`DATA_W-1:0] model_rf [1 << `WARP_W][1 << `REG_W][`NUM_LANES];
    expect_t          exp_q [$];
    integer           seed = 14;

    simt_exec_top u_simt_exec_top (.*);

    always #10 clk = ~clk;

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timeout_abort(input string msg);
        $display("timeout: %s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped on timeout");
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic expect_t predict();
        expect_t            e;
        bit [3:0]           op;
        bit [`DATA_W-1:0]   a;
        bit [`DATA_W-1:0]   b;
        bit [`DATA_W-1:0]   imm;
        int                 prod;
        op       = issue_instr[31:28];
        imm      = {{16{issue_instr[15]}}, issue_instr[15:0]};
        e.wb     = issue_valid && (op <= OP_LID);
        e.br     = issue_valid && (op == OP_BEQ || op == OP_BLT);
        e.warp   = issue_warp;
        e.dst    = issue_instr[27:23];
        e.mask   = issue_mask;
        e.scb    = issue_scb;
        e.target = {14'd0, issue_instr[15:0], 2'b00};   // byte address
        for (int i = 0; i < `NUM_LANES; i++) begin
            a    = model_rf[issue_warp][issue_instr[22:18]][i];
            b    = model_rf[issue_warp][issue_instr[17:13]][i];
            prod = $signed(a[15:0]) * $signed(b[15:0]);
            case (op)
                OP_ADD:  e.data[i] = a + b;
                OP_SUB:  e.data[i] = a - b;
                OP_MUL:  e.data[i] = prod;
                OP_AND:  e.data[i] = a & b;
                OP_OR:   e.data[i] = a | b;
                OP_XOR:  e.data[i] = a ^ b;
                OP_SHR:  e.data[i] = a >> b[4:0];
                OP_SHL:  e.data[i] = a << b[4:0];
                OP_ADDI: e.data[i] = a + imm;
                OP_ANDI: e.data[i] = a & imm;
                OP_ORI:  e.data[i] = a | imm;
                OP_XORI: e.data[i] = a ^ imm;
                OP_LID:  e.data[i] = i;
                default: e.data[i] = '0;
            endcase
            e.taken[i] = issue_mask[i] && ((op == OP_BEQ && a == b) ||
                         (op == OP_BLT && $signed(a[15:0]) < $signed(b[15:0])));
        end
        return e;
    endfunction

    task automatic check_retire(input expect_t e);
        assert (wb_valid === e.wb)
            else report_error($sformatf("wb_valid %b, expected %b", wb_valid, e.wb));
        assert (br_valid === e.br)
            else report_error($sformatf("br_valid %b, expected %b", br_valid, e.br));
        assert (scb_clear_valid === e.br)
            else report_error($sformatf("scb_clear_valid %b, expected %b", scb_clear_valid, e.br));
        if (e.wb) begin
            assert (wb_warp == e.warp && wb_dst == e.dst && wb_mask == e.mask)
                else report_error($sformatf("wb warp/dst/mask %0d/%0d/%h, expected %0d/%0d/%h",
                                            wb_warp, wb_dst, wb_mask, e.warp, e.dst, e.mask));
            for (int i = 0; i < `NUM_LANES; i++) begin
                assert (wb_data[i] == e.data[i])
                    else report_error($sformatf("lane %0d wb_data %h, expected %h",
                                                i, wb_data[i], e.data[i]));
            end
        end
        if (e.br) begin
            assert (br_warp == e.warp && br_taken == e.taken)
                else report_error($sformatf("br warp/taken %0d/%b, expected %0d/%b",
                                            br_warp, br_taken, e.warp, e.taken));
            assert (br_target == e.target)
                else report_error($sformatf("br_target %h, expected %h", br_target, e.target));
            assert (scb_clear_warp == e.warp && scb_clear_id == e.scb)
                else report_error($sformatf("scb clear %0d/%0d, expected %0d/%0d",
                                            scb_clear_warp, scb_clear_id, e.warp, e.scb));
        end
    endtask

    // retire first so an issue on this edge sees the new register values
    always @(posedge clk) begin
        expect_t e;
        if (!rst) begin
            exp_q.delete();
            for (int w = 0; w < (1 << `WARP_W); w++)
                for (int r = 0; r < (1 << `REG_W); r++)
                    for (int i = 0; i < `NUM_LANES; i++)
                        model_rf[w][r][i] = '0;
        end else begin
            if (exp_q.size() >= 3) begin
                e = exp_q.pop_front();
                check_retire(e);
                if (e.wb && e.dst != 0) begin
                    for (int i = 0; i < `NUM_LANES; i++)
                        if (e.mask[i]) model_rf[e.warp][e.dst][i] = e.data[i];
                end
            end
            exp_q.push_back(predict());
        end
    end

    //////////////////////////////////////////////////
    // protocol properties
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst)
        issue_valid && issue_instr[31:28] <= OP_LID |-> ##3 wb_valid && !scb_clear_valid)
        else report_error("write result not seen three edges after issue");
    assert property (@(posedge clk) disable iff (!rst)
        issue_valid && (issue_instr[31:28] == OP_BEQ || issue_instr[31:28] == OP_BLT)
        |-> ##3 br_valid && scb_clear_valid && !wb_valid)
        else report_error("branch outcome not seen three edges after issue");
    assert property (@(posedge clk) disable iff (!rst)
        issue_valid && issue_instr[31:28] == OP_NOP |-> ##3 !wb_valid && !br_valid)
        else report_error("nop raised an output strobe");
    assert property (@(posedge clk) disable iff (!rst) scb_clear_valid == br_valid)
        else report_error("scb_clear_valid differs from br_valid");

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    function automatic bit [31:0] r_word(input bit [3:0] op, input int rd, rs, rt);
        return {op, 5'(rd), 5'(rs), 5'(rt), 13'd0};
    endfunction

    function automatic bit [31:0] i_word(input bit [3:0] op, input int rd, rs,
                                         input bit [15:0] imm);
        return {op, 5'(rd), 5'(rs), 2'b00, imm};
    endfunction

    // rt overlaps the top of the target field
    function automatic bit [31:0] b_word(input bit [3:0] op, input int rs, rt,
                                         input bit [12:0] low);
        return {op, 5'd0, 5'(rs), 5'(rt), low};
    endfunction

    task automatic drive(input bit [`WARP_W-1:0] warp, input bit [`NUM_LANES-1:0] mask,
                         input bit [31:0] word, input bit [`SCB_W-1:0] scb);
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_warp  <= warp;
        issue_mask  <= mask;
        issue_instr <= word;
        issue_scb   <= scb;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            issue_valid <= 1'b0;
        end
    endtask

    // dependent issues four cycles apart need no forwarding
    task automatic send(input bit [`WARP_W-1:0] warp, input bit [`NUM_LANES-1:0] mask,
                        input bit [31:0] word, input bit [`SCB_W-1:0] scb);
        drive(warp, mask, word, scb);
        idle(3);
    endtask

    function automatic int pending();
        int n;
        n = 0;
        foreach (exp_q[k]) if (exp_q[k].wb || exp_q[k].br) n++;
        return n;
    endfunction

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) timeout_abort("pipeline did not drain");
        end
    endtask

    task automatic check_burst(input int n);
        int               cycles;
        bit [`WARP_W-1:0] last;
        cycles = 0;
        @(negedge clk);
        while (!wb_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) timeout_abort("no writeback from the back-to-back issues");
        end
        last = wb_warp;
        repeat (n - 1) begin
            @(negedge clk);
            assert (wb_valid && wb_warp != last)
                else report_error("back-to-back results not on consecutive cycles");
            last = wb_warp;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        bit [3:0] op;
        int       rd;
        int       rs;
        int       rt;
        clk         = 1'b0;
        rst         = 1'b0;
        issue_valid = 1'b0;
        issue_warp  = '0;
        issue_mask  = '0;
        issue_instr = '0;
        issue_scb   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        idle(10);   // quiet outputs checked every edge

        repeat (4) send(3'($random(seed)), 8'($random(seed)), {OP_NOP, 28'd0}, 2'd1);

        // lid then addi merged over it then a read back
        for (int w = 0; w < 2; w++) begin
            send(3'(w), 8'($random(seed)), r_word(OP_LID, 1, 0, 0), 0);
            send(3'(w), 8'($random(seed)), i_word(OP_ADDI, 1, 0, 16'($random(seed))), 0);
            send(3'(w), 8'hff, r_word(OP_OR, 2, 1, 0), 0);
        end

        // lane-varying contents in r1..r15 of every warp
        for (int w = 0; w < 8; w++) begin
            send(3'(w), 8'hff, r_word(OP_LID, 31, 0, 0), 0);
            for (int r = 1; r < 16; r++)
                send(3'(w), 8'hff, i_word(OP_XORI, r, 31, 16'($random(seed))), 0);
        end

        repeat (150) begin
            op = 4'({$random(seed)} % 13);
            rd = 1 + {$random(seed)} % 15;
            rs = {$random(seed)} % 16;
            rt = {$random(seed)} % 16;
            if (op >= OP_ADDI)
                send(3'($random(seed)), 8'($random(seed)),
                     i_word(op, rd, rs, 16'($random(seed))), 0);
            else
                send(3'($random(seed)), 8'($random(seed)), r_word(op, rd, rs, rt), 0);
        end

        // directed compares then random branches
        send(3, 8'hff, i_word(OP_ADDI, 20, 0, 16'd3), 0);
        send(3, 8'hff, r_word(OP_LID, 21, 0, 0), 0);
        send(3, 8'hbe, b_word(OP_BEQ, 21, 20, 13'h0123), 2'd2);   // lane 3 only
        send(3, 8'hff, b_word(OP_BLT, 21, 20, 13'h0040), 2'd1);   // lanes 0 to 2
        send(5, 8'h5a, b_word(OP_BEQ, 7, 7, 13'h1fff), 2'd3);
        repeat (40) begin
            op = ({$random(seed)} % 2) ? OP_BLT : OP_BEQ;
            send(3'($random(seed)), 8'($random(seed)),
                 b_word(op, {$random(seed)} % 32, {$random(seed)} % 32, 13'($random(seed))),
                 2'($random(seed)));
        end

        // three warps in flight at once
        drive(0, 8'hff, r_word(OP_ADD, 9, 1, 2), 0);
        drive(4, 8'h0f, r_word(OP_SUB, 9, 3, 4), 0);
        drive(7, 8'hf0, i_word(OP_ORI, 9, 5, 16'h0f0f), 0);
        idle(1);
        check_burst(3);
        wait_drain();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
